// ==== source/axi_xbar_params.svh ====
// Crossbar sizes and slave address windows, included by the package and every RTL file
`ifndef AXI_XBAR_PARAMS_SVH
`define AXI_XBAR_PARAMS_SVH

`define XBAR_MASTERS 2
`define XBAR_SLAVES 5
`define XBAR_WORD 32      // Address and data width
`define XBAR_PROT_W 3
`define XBAR_STRB_W 4

// Window bases
`define XBAR_BASE_0 32'h0000_0000
`define XBAR_BASE_1 32'h0000_0400
`define XBAR_BASE_2 32'h0000_0408
`define XBAR_BASE_3 32'h0000_0410
`define XBAR_BASE_4 32'h0400_0000

// Set bits are ignored when matching
`define XBAR_MASK_0 32'h0000_03FF
`define XBAR_MASK_1 32'h0000_0001
`define XBAR_MASK_2 32'h0000_0001
`define XBAR_MASK_3 32'h0000_000F
`define XBAR_MASK_4 32'h0000_0000

`endif

// ==== source/axi_xbar_pkg.sv ====
// Shared types of the AXI4-lite crossbar, imported by the arbiters, paths and interface
`include "axi_xbar_params.svh"

package axi_xbar_pkg;

	typedef logic [`XBAR_WORD-1:0] addr_t;
	typedef logic [`XBAR_WORD-1:0] data_t;
	typedef logic [`XBAR_PROT_W-1:0] prot_t;
	typedef logic [`XBAR_STRB_W-1:0] strb_t;

	// Agent indices
	typedef logic [$clog2(`XBAR_MASTERS)-1:0] master_idx_t;
	typedef logic [$clog2(`XBAR_SLAVES)-1:0] slave_idx_t;

	typedef logic [`XBAR_MASTERS-1:0] master_vec_t; // One bit per master

	// Per-direction channel state
	typedef enum logic {
		CHAN_IDLE,
		CHAN_BUSY
	} chan_state_t;

endpackage

// ==== source/grant_if.sv ====
// Request, grant and completion link between one channel arbiter and its routing path
`timescale 1ns/1ps

interface grant_if;
	import axi_xbar_pkg::*;

	master_vec_t req;   // Per-master request
	logic        done;  // Response handshake seen
	master_idx_t grant;
	logic        busy;

	modport arb (
		input  req,
		input  done,
		output grant,
		output busy
	);

	modport path (
		output req,
		output done,
		input  grant,
		input  busy
	);

endinterface

// ==== source/channel_arbiter.sv ====
// Round-robin grant pointer with idle/busy tracking, one instance per read or write direction
`timescale 1ns/1ps
`include "axi_xbar_params.svh"

module channel_arbiter (
	input logic CLK,
	input logic RST,
	grant_if.arb bus_o
);
	import axi_xbar_pkg::*;

	master_idx_t grant_q;
	chan_state_t state_q;

	// Pointer walks the masters until it lands on a requester
	always_ff @(posedge CLK) begin
		if (!RST) begin
			state_q <= CHAN_IDLE;
			grant_q <= '0;
		end else begin
			case (state_q)
				CHAN_IDLE: begin
					if (bus_o.req[grant_q]) begin
						state_q <= CHAN_BUSY; // Lock onto this master
					end else if (grant_q == master_idx_t'(`XBAR_MASTERS - 1)) begin
						grant_q <= '0;
					end else begin
						grant_q <= master_idx_t'(grant_q + 1'b1);
					end
				end
				CHAN_BUSY: begin
					// Pointer frozen until the response completes
					if (bus_o.done) begin
						state_q <= CHAN_IDLE;
					end
				end
				default: begin
					state_q <= CHAN_IDLE;
				end
			endcase
		end
	end

	assign bus_o.grant = grant_q;
	assign bus_o.busy  = (state_q == CHAN_BUSY);

endmodule

// ==== source/slave_decoder.sv ====
// Address to slave index decode over the fixed window map, lowest matching slave wins
`timescale 1ns/1ps
`include "axi_xbar_params.svh"

module slave_decoder (
	input  axi_xbar_pkg::addr_t      addr_i,
	output axi_xbar_pkg::slave_idx_t slave_o,
	output logic                     hit_o
);
	import axi_xbar_pkg::*;

	localparam addr_t [`XBAR_SLAVES-1:0] slave_base = {
		`XBAR_BASE_4, `XBAR_BASE_3, `XBAR_BASE_2, `XBAR_BASE_1, `XBAR_BASE_0
	};
	localparam addr_t [`XBAR_SLAVES-1:0] slave_mask = {
		`XBAR_MASK_4, `XBAR_MASK_3, `XBAR_MASK_2, `XBAR_MASK_1, `XBAR_MASK_0
	};

	logic [`XBAR_SLAVES-1:0] match;

	// Compare only the bits the mask leaves at zero
	for (genvar i = 0; i < `XBAR_SLAVES; i++) begin : g_win
		assign match[i] = ((addr_i ^ slave_base[i]) & ~slave_mask[i]) == '0;
	end

	// Priority encoder, scanned from the top so the lowest index is last written
	always_comb begin
		slave_o = '0;
		for (int i = `XBAR_SLAVES - 1; i >= 0; i--) begin
			if (match[i]) begin
				slave_o = slave_idx_t'(i);
			end
		end
	end

	assign hit_o = |match; // Any window at all

endmodule

// ==== source/write_path.sv ====
// Write address, data and response routing between the granted master and its decoded slave
`timescale 1ns/1ps
`include "axi_xbar_params.svh"

module write_path (
	input  logic                                        CLK,
	input  logic                                        RST,
	input  axi_xbar_pkg::master_vec_t                   m_awvalid_i,
	input  axi_xbar_pkg::addr_t [`XBAR_MASTERS-1:0]     m_awaddr_i,
	input  axi_xbar_pkg::prot_t [`XBAR_MASTERS-1:0]     m_awprot_i,
	input  axi_xbar_pkg::master_vec_t                   m_wvalid_i,
	input  axi_xbar_pkg::data_t [`XBAR_MASTERS-1:0]     m_wdata_i,
	input  axi_xbar_pkg::strb_t [`XBAR_MASTERS-1:0]     m_wstrb_i,
	input  axi_xbar_pkg::master_vec_t                   m_bready_i,
	output axi_xbar_pkg::master_vec_t                   m_awready_o,
	output axi_xbar_pkg::master_vec_t                   m_wready_o,
	output axi_xbar_pkg::master_vec_t                   m_bvalid_o,
	output logic                [`XBAR_SLAVES-1:0]      s_awvalid_o,
	output axi_xbar_pkg::addr_t [`XBAR_SLAVES-1:0]      s_awaddr_o,
	output axi_xbar_pkg::prot_t [`XBAR_SLAVES-1:0]      s_awprot_o,
	output logic                [`XBAR_SLAVES-1:0]      s_wvalid_o,
	output axi_xbar_pkg::data_t [`XBAR_SLAVES-1:0]      s_wdata_o,
	output axi_xbar_pkg::strb_t [`XBAR_SLAVES-1:0]      s_wstrb_o,
	output logic                [`XBAR_SLAVES-1:0]      s_bready_o,
	input  logic                [`XBAR_SLAVES-1:0]      s_awready_i,
	input  logic                [`XBAR_SLAVES-1:0]      s_wready_i,
	input  logic                [`XBAR_SLAVES-1:0]      s_bvalid_i,
	grant_if.path                                       arb_io
);
	import axi_xbar_pkg::*;

	logic       awvalid_g;
	addr_t      awaddr_g;
	slave_idx_t dec_slave, sel_q, sel;
	logic       dec_hit, hit_q, sel_hit;
	logic       route;

	assign awvalid_g = m_awvalid_i[arb_io.grant];
	assign awaddr_g  = m_awaddr_i[arb_io.grant];

	slave_decoder u_dec (
		.addr_i (awaddr_g),
		.slave_o(dec_slave),
		.hit_o  (dec_hit)
	);

	// Keep the last decode once awaddr is no longer valid, the B response still needs it
	always_ff @(posedge CLK) begin
		if (!RST) begin
			sel_q <= '0;
			hit_q <= 1'b0;
		end else if (awvalid_g) begin
			sel_q <= dec_slave;
			hit_q <= dec_hit;
		end
	end

	assign sel     = awvalid_g ? dec_slave : sel_q;
	assign sel_hit = awvalid_g ? dec_hit : hit_q;
	assign route   = arb_io.busy & sel_hit;

	assign arb_io.req  = m_awvalid_i | m_wvalid_i; // AW or W may come first
	assign arb_io.done = route & s_bvalid_i[sel] & m_bready_i[arb_io.grant];

	// Forward channels to the selected slave only
	for (genvar s = 0; s < `XBAR_SLAVES; s++) begin : g_slave
		logic en;
		assign en             = route && (sel == slave_idx_t'(s));
		assign s_awvalid_o[s] = en & awvalid_g;
		assign s_awaddr_o[s]  = en ? awaddr_g : '0;
		assign s_awprot_o[s]  = en ? m_awprot_i[arb_io.grant] : '0;
		assign s_wvalid_o[s]  = en & m_wvalid_i[arb_io.grant];
		assign s_wdata_o[s]   = en ? m_wdata_i[arb_io.grant] : '0;
		assign s_wstrb_o[s]   = en ? m_wstrb_i[arb_io.grant] : '0;
		assign s_bready_o[s]  = en & m_bready_i[arb_io.grant];
	end

	// Return channels to the granted master only
	for (genvar m = 0; m < `XBAR_MASTERS; m++) begin : g_master
		logic en;
		assign en             = route && (arb_io.grant == master_idx_t'(m));
		assign m_awready_o[m] = en & s_awready_i[sel];
		assign m_wready_o[m]  = en & s_wready_i[sel];
		assign m_bvalid_o[m]  = en & s_bvalid_i[sel];
	end

endmodule

// ==== source/read_path.sv ====
// Read address and read data routing between the granted master and its decoded slave
`timescale 1ns/1ps
`include "axi_xbar_params.svh"

module read_path (
	input  logic                                        CLK,
	input  logic                                        RST,
	input  axi_xbar_pkg::master_vec_t                   m_arvalid_i,
	input  axi_xbar_pkg::addr_t [`XBAR_MASTERS-1:0]     m_araddr_i,
	input  axi_xbar_pkg::prot_t [`XBAR_MASTERS-1:0]     m_arprot_i,
	input  axi_xbar_pkg::master_vec_t                   m_rready_i,
	output axi_xbar_pkg::master_vec_t                   m_arready_o,
	output axi_xbar_pkg::master_vec_t                   m_rvalid_o,
	output axi_xbar_pkg::data_t [`XBAR_MASTERS-1:0]     m_rdata_o,
	output logic                [`XBAR_SLAVES-1:0]      s_arvalid_o,
	output axi_xbar_pkg::addr_t [`XBAR_SLAVES-1:0]      s_araddr_o,
	output axi_xbar_pkg::prot_t [`XBAR_SLAVES-1:0]      s_arprot_o,
	output logic                [`XBAR_SLAVES-1:0]      s_rready_o,
	input  logic                [`XBAR_SLAVES-1:0]      s_arready_i,
	input  logic                [`XBAR_SLAVES-1:0]      s_rvalid_i,
	input  axi_xbar_pkg::data_t [`XBAR_SLAVES-1:0]      s_rdata_i,
	grant_if.path                                       arb_io
);
	import axi_xbar_pkg::*;

	logic       arvalid_g;
	addr_t      araddr_g;
	slave_idx_t dec_slave, sel_q, sel;
	logic       dec_hit, hit_q, sel_hit;
	logic       route;

	assign arvalid_g = m_arvalid_i[arb_io.grant];
	assign araddr_g  = m_araddr_i[arb_io.grant];

	slave_decoder u_dec (
		.addr_i (araddr_g),
		.slave_o(dec_slave),
		.hit_o  (dec_hit)
	);

	// Decode held past the AR handshake for the R beat
	always_ff @(posedge CLK) begin
		if (!RST) begin
			sel_q <= '0;
			hit_q <= 1'b0;
		end else if (arvalid_g) begin
			sel_q <= dec_slave;
			hit_q <= dec_hit;
		end
	end

	assign sel     = arvalid_g ? dec_slave : sel_q;
	assign sel_hit = arvalid_g ? dec_hit : hit_q;
	assign route   = arb_io.busy & sel_hit;

	assign arb_io.req  = m_arvalid_i;
	assign arb_io.done = route & s_rvalid_i[sel] & m_rready_i[arb_io.grant];

	for (genvar s = 0; s < `XBAR_SLAVES; s++) begin : g_slave
		logic en;
		assign en             = route && (sel == slave_idx_t'(s));
		assign s_arvalid_o[s] = en & arvalid_g;
		assign s_araddr_o[s]  = en ? araddr_g : '0;
		assign s_arprot_o[s]  = en ? m_arprot_i[arb_io.grant] : '0;
		assign s_rready_o[s]  = en & m_rready_i[arb_io.grant];
	end

	for (genvar m = 0; m < `XBAR_MASTERS; m++) begin : g_master
		logic en;
		assign en             = route && (arb_io.grant == master_idx_t'(m));
		assign m_arready_o[m] = en & s_arready_i[sel];
		assign m_rvalid_o[m]  = en & s_rvalid_i[sel];
		assign m_rdata_o[m]   = en ? s_rdata_i[sel] : '0; // Zero when not ours
	end

endmodule

// ==== source/axi_xbar_top.sv ====
// Two-master, five-slave AXI4-lite crossbar top with flat per-agent ports
`timescale 1ns/1ps
`include "axi_xbar_params.svh"

module axi_xbar_top (
	input  logic                                 CLK,
	input  logic                                 RST,
	input  logic [`XBAR_MASTERS-1:0]             m_axi_awvalid_i,
	output logic [`XBAR_MASTERS-1:0]             m_axi_awready_o,
	input  logic [`XBAR_MASTERS*`XBAR_WORD-1:0]   m_axi_awaddr_i,
	input  logic [`XBAR_MASTERS*`XBAR_PROT_W-1:0] m_axi_awprot_i,
	input  logic [`XBAR_MASTERS-1:0]             m_axi_wvalid_i,
	output logic [`XBAR_MASTERS-1:0]             m_axi_wready_o,
	input  logic [`XBAR_MASTERS*`XBAR_WORD-1:0]   m_axi_wdata_i,
	input  logic [`XBAR_MASTERS*`XBAR_STRB_W-1:0] m_axi_wstrb_i,
	output logic [`XBAR_MASTERS-1:0]             m_axi_bvalid_o,
	input  logic [`XBAR_MASTERS-1:0]             m_axi_bready_i,
	input  logic [`XBAR_MASTERS-1:0]             m_axi_arvalid_i,
	output logic [`XBAR_MASTERS-1:0]             m_axi_arready_o,
	input  logic [`XBAR_MASTERS*`XBAR_WORD-1:0]   m_axi_araddr_i,
	input  logic [`XBAR_MASTERS*`XBAR_PROT_W-1:0] m_axi_arprot_i,
	output logic [`XBAR_MASTERS-1:0]             m_axi_rvalid_o,
	input  logic [`XBAR_MASTERS-1:0]             m_axi_rready_i,
	output logic [`XBAR_MASTERS*`XBAR_WORD-1:0]   m_axi_rdata_o,
	output logic [`XBAR_SLAVES-1:0]              s_axi_awvalid_o,
	input  logic [`XBAR_SLAVES-1:0]              s_axi_awready_i,
	output logic [`XBAR_SLAVES*`XBAR_WORD-1:0]    s_axi_awaddr_o,
	output logic [`XBAR_SLAVES*`XBAR_PROT_W-1:0]  s_axi_awprot_o,
	output logic [`XBAR_SLAVES-1:0]              s_axi_wvalid_o,
	input  logic [`XBAR_SLAVES-1:0]              s_axi_wready_i,
	output logic [`XBAR_SLAVES*`XBAR_WORD-1:0]    s_axi_wdata_o,
	output logic [`XBAR_SLAVES*`XBAR_STRB_W-1:0]  s_axi_wstrb_o,
	input  logic [`XBAR_SLAVES-1:0]              s_axi_bvalid_i,
	output logic [`XBAR_SLAVES-1:0]              s_axi_bready_o,
	output logic [`XBAR_SLAVES-1:0]              s_axi_arvalid_o,
	input  logic [`XBAR_SLAVES-1:0]              s_axi_arready_i,
	output logic [`XBAR_SLAVES*`XBAR_WORD-1:0]    s_axi_araddr_o,
	output logic [`XBAR_SLAVES*`XBAR_PROT_W-1:0]  s_axi_arprot_o,
	input  logic [`XBAR_SLAVES-1:0]              s_axi_rvalid_i,
	output logic [`XBAR_SLAVES-1:0]              s_axi_rready_o,
	input  logic [`XBAR_SLAVES*`XBAR_WORD-1:0]    s_axi_rdata_i
);

	// Write and read directions arbitrate independently
	grant_if wr_bus ();
	grant_if rd_bus ();

	channel_arbiter u_wr_arb (.CLK(CLK), .RST(RST), .bus_o(wr_bus));
	channel_arbiter u_rd_arb (.CLK(CLK), .RST(RST), .bus_o(rd_bus));

	write_path u_write_path (
		.CLK(CLK), .RST(RST),
		.m_awvalid_i(m_axi_awvalid_i), .m_awaddr_i(m_axi_awaddr_i),
		.m_awprot_i(m_axi_awprot_i), .m_wvalid_i(m_axi_wvalid_i),
		.m_wdata_i(m_axi_wdata_i), .m_wstrb_i(m_axi_wstrb_i),
		.m_bready_i(m_axi_bready_i), .m_awready_o(m_axi_awready_o),
		.m_wready_o(m_axi_wready_o), .m_bvalid_o(m_axi_bvalid_o),
		.s_awvalid_o(s_axi_awvalid_o), .s_awaddr_o(s_axi_awaddr_o),
		.s_awprot_o(s_axi_awprot_o), .s_wvalid_o(s_axi_wvalid_o),
		.s_wdata_o(s_axi_wdata_o), .s_wstrb_o(s_axi_wstrb_o),
		.s_bready_o(s_axi_bready_o), .s_awready_i(s_axi_awready_i),
		.s_wready_i(s_axi_wready_i), .s_bvalid_i(s_axi_bvalid_i),
		.arb_io(wr_bus)
	);

	read_path u_read_path (
		.CLK(CLK), .RST(RST),
		.m_arvalid_i(m_axi_arvalid_i), .m_araddr_i(m_axi_araddr_i),
		.m_arprot_i(m_axi_arprot_i), .m_rready_i(m_axi_rready_i),
		.m_arready_o(m_axi_arready_o), .m_rvalid_o(m_axi_rvalid_o),
		.m_rdata_o(m_axi_rdata_o),
		.s_arvalid_o(s_axi_arvalid_o), .s_araddr_o(s_axi_araddr_o),
		.s_arprot_o(s_axi_arprot_o), .s_rready_o(s_axi_rready_o),
		.s_arready_i(s_axi_arready_i), .s_rvalid_i(s_axi_rvalid_i),
		.s_rdata_i(s_axi_rdata_i),
		.arb_io(rd_bus)
	);

endmodule

// ==== bench/axi_xbar_sva.sv ====
// Protocol assertions for the crossbar, attached to every axi_xbar_top instance by bind
`timescale 1ns/1ps
`include "axi_xbar_params.svh"

module axi_xbar_sva (
	input logic                     CLK,
	input logic                     RST,
	input logic [`XBAR_SLAVES-1:0]  s_awvalid_i,
	input logic [`XBAR_SLAVES-1:0]  s_arvalid_i,
	input logic [`XBAR_MASTERS-1:0] m_rvalid_i,
	input logic                     rd_busy_i
);

	// Only the decoded slave may see a request
	a_aw_onehot: assert property (@(posedge CLK) disable iff (!RST) $onehot0(s_awvalid_i))
		else $error("awvalid seen by more than one slave");
	a_ar_onehot: assert property (@(posedge CLK) disable iff (!RST) $onehot0(s_arvalid_i))
		else $error("arvalid seen by more than one slave");

	// Read data returns only inside a granted transaction
	a_r_idle: assert property (@(posedge CLK) disable iff (!RST)
		!rd_busy_i |-> (m_rvalid_i == '0))
		else $error("rvalid to a master while the read channel is idle");

endmodule

bind axi_xbar_top axi_xbar_sva u_axi_xbar_sva (
	.CLK        (CLK),
	.RST        (RST),
	.s_awvalid_i(s_axi_awvalid_o),
	.s_arvalid_i(s_axi_arvalid_o),
	.m_rvalid_i (m_axi_rvalid_o),
	.rd_busy_i  (rd_bus.busy)
);

// ==== bench/tb_axi_xbar.sv ====
// Directed testbench for the AXI4-lite crossbar, with simple slave responders and checking tasks
`timescale 1ns/1ps
`include "axi_xbar_params.svh"

module tb_axi_xbar;

	localparam int MAX_CYCLES = 2000; // About 20 transactions of ~10 cycles, wide margin

	logic CLK = 1'b0;
	logic RST = 1'b0;

	logic [`XBAR_MASTERS-1:0] m_axi_awvalid_i = '0, m_axi_wvalid_i = '0, m_axi_bready_i = '0;
	logic [`XBAR_MASTERS-1:0] m_axi_arvalid_i = '0, m_axi_rready_i = '0;
	logic [`XBAR_MASTERS*`XBAR_WORD-1:0] m_axi_awaddr_i = '0, m_axi_wdata_i = '0;
	logic [`XBAR_MASTERS*`XBAR_WORD-1:0] m_axi_araddr_i = '0;
	logic [`XBAR_MASTERS*`XBAR_PROT_W-1:0] m_axi_awprot_i = '0, m_axi_arprot_i = '0;
	logic [`XBAR_MASTERS*`XBAR_STRB_W-1:0] m_axi_wstrb_i = '0;
	logic [`XBAR_MASTERS-1:0] m_axi_awready_o, m_axi_wready_o, m_axi_bvalid_o;
	logic [`XBAR_MASTERS-1:0] m_axi_arready_o, m_axi_rvalid_o;
	logic [`XBAR_MASTERS*`XBAR_WORD-1:0] m_axi_rdata_o;

	// Slave inputs, owned by the responders
	logic [`XBAR_SLAVES-1:0] s_axi_awready_i = '0, s_axi_wready_i = '0, s_axi_bvalid_i = '0;
	logic [`XBAR_SLAVES-1:0] s_axi_arready_i = '0, s_axi_rvalid_i = '0;
	logic [`XBAR_SLAVES*`XBAR_WORD-1:0] s_axi_rdata_i = '0;
	logic [`XBAR_SLAVES-1:0] s_axi_awvalid_o, s_axi_wvalid_o, s_axi_bready_o;
	logic [`XBAR_SLAVES-1:0] s_axi_arvalid_o, s_axi_rready_o;
	logic [`XBAR_SLAVES*`XBAR_WORD-1:0] s_axi_awaddr_o, s_axi_wdata_o, s_axi_araddr_o;
	logic [`XBAR_SLAVES*`XBAR_PROT_W-1:0] s_axi_awprot_o, s_axi_arprot_o;
	logic [`XBAR_SLAVES*`XBAR_STRB_W-1:0] s_axi_wstrb_o;

	// Responder state and what each slave last accepted
	logic [31:0] mem [`XBAR_SLAVES][4] = '{default: '0};
	logic [31:0] got_awaddr [`XBAR_SLAVES] = '{default: '0};
	logic [31:0] got_wdata [`XBAR_SLAVES] = '{default: '0};
	logic [3:0]  got_wstrb [`XBAR_SLAVES] = '{default: '0};
	logic [2:0]  got_awprot [`XBAR_SLAVES] = '{default: '0};
	logic [31:0] got_araddr [`XBAR_SLAVES] = '{default: '0};
	logic [2:0]  got_arprot [`XBAR_SLAVES] = '{default: '0};
	bit          aw_seen [`XBAR_SLAVES] = '{default: 1'b0};
	bit          w_seen [`XBAR_SLAVES] = '{default: 1'b0};
	int          aw_cnt [`XBAR_SLAVES] = '{default: 0};
	int          ar_cnt [`XBAR_SLAVES] = '{default: 0};
	int          exp_aw [`XBAR_SLAVES] = '{default: 0};
	int          exp_ar [`XBAR_SLAVES] = '{default: 0};

	// Entry i lies in window i of the map
	logic [31:0] addr_tab [`XBAR_SLAVES] = '{32'h0000_0010, 32'h0000_0400, 32'h0000_0409,
		32'h0000_0414, 32'h0400_0000};
	logic [31:0] wr_data [`XBAR_SLAVES];
	logic [3:0]  wr_strb [`XBAR_SLAVES];

	bit [`XBAR_MASTERS-1:0] serving = '0; // Master between first ready and B handshake
	int seed = 32'hede3;
	int cycles = 0;
	int tests = 0;
	int checks = 0;
	int errors = 0;

	axi_xbar_top u_axi_xbar_top (.*);

	always #20 CLK = ~CLK;

	always @(posedge CLK) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout: tests still running after %0d cycles", cycles);
			$display("Something failed");
			$finish;
		end
	end

	// Slave responders, sampled mid-cycle and updated just after the edge
	always @(negedge CLK) begin : responders
		logic [`XBAR_SLAVES-1:0] awv, wv, brdy, arv, rrdy;
		logic [`XBAR_SLAVES*`XBAR_WORD-1:0] awa, wd, ara;
		logic [`XBAR_SLAVES*`XBAR_STRB_W-1:0] ws;
		logic [`XBAR_SLAVES*`XBAR_PROT_W-1:0] awp, arp;
		logic [31:0] mask;
		awv = s_axi_awvalid_o;
		wv = s_axi_wvalid_o;
		brdy = s_axi_bready_o;
		arv = s_axi_arvalid_o;
		rrdy = s_axi_rready_o;
		awa = s_axi_awaddr_o;
		wd = s_axi_wdata_o;
		ws = s_axi_wstrb_o;
		ara = s_axi_araddr_o;
		awp = s_axi_awprot_o;
		arp = s_axi_arprot_o;
		@(posedge CLK);
		#2;
		for (int s = 0; s < `XBAR_SLAVES; s++) begin
			if (awv[s] && s_axi_awready_i[s]) begin
				s_axi_awready_i[s] = 1'b0;
				aw_seen[s] = 1'b1;
				got_awaddr[s] = awa[s*32 +: 32];
				got_awprot[s] = awp[s*3 +: 3];
				aw_cnt[s]++;
			end else if (awv[s] && !aw_seen[s]) begin
				s_axi_awready_i[s] = 1'b1;
			end
			if (wv[s] && s_axi_wready_i[s]) begin
				s_axi_wready_i[s] = 1'b0;
				w_seen[s] = 1'b1;
				got_wdata[s] = wd[s*32 +: 32];
				got_wstrb[s] = ws[s*4 +: 4];
			end else if (wv[s] && !w_seen[s]) begin
				s_axi_wready_i[s] = 1'b1;
			end
			if (s_axi_bvalid_i[s] && brdy[s]) begin
				s_axi_bvalid_i[s] = 1'b0;
				aw_seen[s] = 1'b0;
				w_seen[s] = 1'b0;
			end else if (aw_seen[s] && w_seen[s] && !s_axi_bvalid_i[s]) begin
				mask = strb_mask(got_wstrb[s]);
				mem[s][got_awaddr[s][1:0]] = (mem[s][got_awaddr[s][1:0]] & ~mask) |
					(got_wdata[s] & mask);
				s_axi_bvalid_i[s] = 1'b1;
			end
			if (s_axi_rvalid_i[s] && rrdy[s]) begin
				s_axi_rvalid_i[s] = 1'b0;
				s_axi_rdata_i[s*32 +: 32] = '0;
			end
			if (arv[s] && s_axi_arready_i[s]) begin
				s_axi_arready_i[s] = 1'b0;
				s_axi_rvalid_i[s] = 1'b1;
				s_axi_rdata_i[s*32 +: 32] = mem[s][ara[s*32 +: 2]] ^ 32'(s); // Tagged by slave
				got_araddr[s] = ara[s*32 +: 32];
				got_arprot[s] = arp[s*3 +: 3];
				ar_cnt[s]++;
			end else if (arv[s] && !s_axi_rvalid_i[s]) begin
				s_axi_arready_i[s] = 1'b1;
			end
		end
	end

	function automatic logic [31:0] strb_mask(input logic [3:0] strb);
		for (int b = 0; b < 4; b++) begin
			strb_mask[b*8 +: 8] = {8{strb[b]}};
		end
	endfunction

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		assert (got === exp)
		else begin
			errors++;
			$display("CHECK FAILED at %0t ns: %s = 0x%h, expected 0x%h", $time, name, got, exp);
		end
	endtask

	task automatic check_counts();
		for (int s = 0; s < `XBAR_SLAVES; s++) begin
			check_val($sformatf("s_axi_awvalid_o[%0d] count", s), aw_cnt[s], exp_aw[s]);
			check_val($sformatf("s_axi_arvalid_o[%0d] count", s), ar_cnt[s], exp_ar[s]);
		end
	endtask

	task automatic finish_test(input string name, input int errs_before);
		tests++;
		$display("Test %0d %s finished with %0d errors", tests, name, errors - errs_before);
	endtask

	// Full AW, W and B sequence for one master, called just after an edge
	task automatic axi_write(input int m, input logic [31:0] addr, input logic [31:0] data,
		input logic [3:0] strb);
		bit aw_hs, w_hs, b_hs;
		m_axi_awaddr_i[m*32 +: 32] = addr;
		m_axi_wdata_i[m*32 +: 32] = data;
		m_axi_wstrb_i[m*4 +: 4] = strb;
		m_axi_awvalid_i[m] = 1'b1;
		m_axi_wvalid_i[m] = 1'b1;
		m_axi_bready_i[m] = 1'b1;
		b_hs = 1'b0;
		while (!b_hs) begin
			@(negedge CLK);
			if (m_axi_awready_o[m] || m_axi_wready_o[m]) serving[m] = 1'b1;
			aw_hs = m_axi_awvalid_i[m] & m_axi_awready_o[m];
			w_hs = m_axi_wvalid_i[m] & m_axi_wready_o[m];
			b_hs = m_axi_bvalid_o[m] & m_axi_bready_i[m];
			@(posedge CLK);
			#2;
			if (aw_hs) m_axi_awvalid_i[m] = 1'b0;
			if (w_hs) m_axi_wvalid_i[m] = 1'b0;
		end
		m_axi_bready_i[m] = 1'b0;
		serving[m] = 1'b0;
	endtask

	task automatic axi_read(input int m, input logic [31:0] addr, output logic [31:0] data);
		bit ar_hs, r_hs;
		m_axi_araddr_i[m*32 +: 32] = addr;
		m_axi_arvalid_i[m] = 1'b1;
		m_axi_rready_i[m] = 1'b1;
		r_hs = 1'b0;
		while (!r_hs) begin
			@(negedge CLK);
			ar_hs = m_axi_arvalid_i[m] & m_axi_arready_o[m];
			r_hs = m_axi_rvalid_o[m] & m_axi_rready_i[m];
			if (r_hs) data = m_axi_rdata_o[m*32 +: 32];
			@(posedge CLK);
			#2;
			if (ar_hs) m_axi_arvalid_i[m] = 1'b0;
		end
		m_axi_rready_i[m] = 1'b0;
	endtask

	task automatic test_reset_outputs();
		int e0;
		e0 = errors;
		@(negedge CLK);
		check_val("m_axi_awready_o", m_axi_awready_o, '0);
		check_val("m_axi_wready_o", m_axi_wready_o, '0);
		check_val("m_axi_bvalid_o", m_axi_bvalid_o, '0);
		check_val("m_axi_arready_o", m_axi_arready_o, '0);
		check_val("m_axi_rvalid_o", m_axi_rvalid_o, '0);
		check_val("s_axi_awvalid_o", s_axi_awvalid_o, '0);
		check_val("s_axi_wvalid_o", s_axi_wvalid_o, '0);
		check_val("s_axi_bready_o", s_axi_bready_o, '0);
		check_val("s_axi_arvalid_o", s_axi_arvalid_o, '0);
		check_val("s_axi_rready_o", s_axi_rready_o, '0);
		@(posedge CLK);
		#2;
		finish_test("reset outputs", e0);
	endtask

	task automatic test_write_each_slave();
		int e0;
		logic [2:0] prot;
		e0 = errors;
		for (int s = 0; s < `XBAR_SLAVES; s++) begin
			wr_data[s] = $random(seed);
			wr_strb[s] = 4'($random(seed));
			prot = 3'($random(seed));
			m_axi_awprot_i[2:0] = prot; // Master 0 field
			axi_write(0, addr_tab[s], wr_data[s], wr_strb[s]);
			exp_aw[s]++;
			check_val($sformatf("s_axi_awaddr_o[%0d]", s), got_awaddr[s], addr_tab[s]);
			check_val($sformatf("s_axi_wdata_o[%0d]", s), got_wdata[s], wr_data[s]);
			check_val($sformatf("s_axi_wstrb_o[%0d]", s), got_wstrb[s], wr_strb[s]);
			check_val($sformatf("s_axi_awprot_o[%0d]", s), got_awprot[s], prot);
			check_counts();
		end
		finish_test("write to each slave", e0);
	endtask

	task automatic test_read_back();
		int e0;
		logic [31:0] rd;
		logic [2:0] prot;
		e0 = errors;
		for (int s = 0; s < `XBAR_SLAVES; s++) begin
			prot = 3'($random(seed));
			m_axi_arprot_i[5:3] = prot; // Master 1 field
			axi_read(1, addr_tab[s], rd);
			exp_ar[s]++;
			check_val($sformatf("m_axi_rdata_o[1] from slave %0d", s), rd,
				(wr_data[s] & strb_mask(wr_strb[s])) ^ 32'(s));
			check_val($sformatf("s_axi_araddr_o[%0d]", s), got_araddr[s], addr_tab[s]);
			check_val($sformatf("s_axi_arprot_o[%0d]", s), got_arprot[s], prot);
			check_counts();
		end
		finish_test("read back", e0);
	endtask

	// Both masters write at once, the waiting one must never see awready
	task automatic test_write_contention();
		int e0;
		bit done0, done1;
		logic [31:0] d0, d1;
		e0 = errors;
		done0 = 1'b0;
		done1 = 1'b0;
		d0 = $random(seed);
		d1 = $random(seed);
		fork
			begin
				axi_write(0, 32'h0000_0418, d0, 4'hF);
				done0 = 1'b1;
			end
			begin
				axi_write(1, 32'h0000_0100, d1, 4'hF);
				done1 = 1'b1;
			end
			while (!(done0 && done1)) begin
				@(negedge CLK);
				#1;
				if (serving[0]) check_val("m_axi_awready_o[1]", m_axi_awready_o[1], '0);
				if (serving[1]) check_val("m_axi_awready_o[0]", m_axi_awready_o[0], '0);
			end
		join
		exp_aw[3]++;
		exp_aw[0]++;
		check_val("s_axi_awaddr_o[3]", got_awaddr[3], 32'h0000_0418);
		check_val("s_axi_wdata_o[3]", got_wdata[3], d0);
		check_val("s_axi_awaddr_o[0]", got_awaddr[0], 32'h0000_0100);
		check_val("s_axi_wdata_o[0]", got_wdata[0], d1);
		check_counts();
		finish_test("write contention", e0);
	endtask

	task automatic test_read_write_overlap();
		int e0;
		logic [31:0] d, rd;
		e0 = errors;
		d = $random(seed);
		fork
			axi_write(0, 32'h0000_0408, d, 4'hF);
			axi_read(1, 32'h0400_0000, rd);
		join
		exp_aw[2]++;
		exp_ar[4]++;
		check_val("s_axi_wdata_o[2]", got_wdata[2], d);
		check_val("m_axi_rdata_o[1]", rd, (wr_data[4] & strb_mask(wr_strb[4])) ^ 32'd4);
		check_counts();
		finish_test("read and write overlap", e0);
	endtask

	task automatic test_window_edges();
		int e0;
		logic [31:0] d0, d1, rd;
		e0 = errors;
		d0 = $random(seed);
		d1 = $random(seed);
		axi_write(1, 32'h0000_0401, d0, 4'hF);
		exp_aw[1]++;
		axi_write(1, 32'h0000_041F, d1, 4'hF);
		exp_aw[3]++;
		check_val("s_axi_awaddr_o[3]", got_awaddr[3], 32'h0000_041F);
		axi_read(0, 32'h0000_041F, rd);
		exp_ar[3]++;
		check_val("m_axi_rdata_o[0] at 0x41F", rd, d1 ^ 32'd3);
		axi_read(0, 32'h0000_0401, rd);
		exp_ar[1]++;
		check_val("m_axi_rdata_o[0] at 0x401", rd, d0 ^ 32'd1);
		check_counts();
		finish_test("window edges", e0);
	endtask

	initial begin : main
		repeat (3) @(posedge CLK);
		#2;
		RST = 1'b1;
		test_reset_outputs();
		test_write_each_slave();
		test_read_back();
		test_write_contention();
		test_read_write_overlap();
		test_window_edges();
		$display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

// ==== vlog.f ====
+incdir+source
source/axi_xbar_pkg.sv
source/grant_if.sv
source/channel_arbiter.sv
source/slave_decoder.sv
source/write_path.sv
source/read_path.sv
source/axi_xbar_top.sv
bench/axi_xbar_sva.sv
bench/tb_axi_xbar.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the crossbar testbench with Verilator and run it once
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 \
	-f vlog.f --top-module tb_axi_xbar -o sim_axi_xbar

# The simulator status alone is not trusted, the printed verdict decides
out="$(./obj_dir/sim_axi_xbar 2>&1)" || true
echo "$out"

if grep -qx "Everything OK" <<< "$out"; then
	exit 0
fi
echo "Simulation did not pass"
exit 1
